// File: verilog/ql_bus_pkg.sv
// Bus types, CPU speed and RAM size encodings
// Address wrap masks and register constants for the QL bus glue
package ql_bus_pkg;

	typedef logic [23:0] bus_addr_t;	// CPU byte address
	typedef logic [15:0] bus_word_t;	// Data bus word
	typedef logic [16:0] frac_t;		// Accumulator step, 65536 means every clk_sys

	// CPU bus speed selection
	typedef enum logic [1:0]
	{
		speed_ql   = 2'd0,		// Original QL, about 15 MHz of ticks
		speed_16   = 2'd1,
		speed_24   = 2'd2,
		speed_full = 2'd3		// Tick on every clock
	} cpu_speed_t;

	// RAM fitted
	typedef enum logic [1:0]
	{
		ram_128k  = 2'd0,
		ram_640k  = 2'd1,
		ram_896k  = 2'd2,
		ram_4096k = 2'd3		// Also switches GoldCard mode on
	} ram_cfg_t;

	// Address wrap masks
	localparam bus_addr_t MASK_128K = 24'h03FFFF;	// Wrap at 256k
	localparam bus_addr_t MASK_1M   = 24'h0FFFFF;	// 640k and 896k systems
	localparam bus_addr_t MASK_8M   = 24'h7FFFFF;	// 4M RAM plus GoldCard spaces

	// GoldCard I/O offsets, low address byte
	localparam logic [7:0] GLO_RENA = 8'h60;		// Shadow RAM on
	localparam logic [7:0] GLO_RDIS = 8'h64;		// Shadow RAM off

	localparam logic [15:0] QLSD_DATA_ADDR = 16'hFEE4;	// Only QL-SD register with data
	localparam bus_word_t   IDLE_WORD      = 16'hFFFF;	// Unmapped read
	localparam logic [7:0]  VRAM_BANK      = 8'h02;		// Video RAM at 20000h

endpackage

// File: verilog/clock_enables.sv
`timescale 1ns/100ps
// Fractional CPU bus enables, phase 1 and phase 2 alternating
// Integer-divided refresh/RTC and pixel enables
module clock_enables
#(
	parameter ql_bus_pkg::frac_t FRACT_QL   = 17'd11702,
	parameter ql_bus_pkg::frac_t FRACT_16   = 17'd24966,
	parameter ql_bus_pkg::frac_t FRACT_24   = 17'd37449,
	parameter ql_bus_pkg::frac_t FRACT_FULL = 17'd65536,
	parameter int unsigned       DIV_131K   = 640,
	parameter int unsigned       DIV_VID    = 8
)
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_bus_pkg::cpu_speed_t cpu_speed,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   ce_131k,
	output logic                   ce_vid
);
	import ql_bus_pkg::*;

	localparam int unsigned DIV_MAX = (DIV_131K > DIV_VID) ? DIV_131K : DIV_VID;
	localparam int unsigned DIV_W   = $clog2(DIV_MAX);
	// Terminal counts, index 0 refresh, index 1 pixel
	localparam logic [DIV_W-1:0] DIV_LAST [2] = '{DIV_W'(DIV_131K - 1), DIV_W'(DIV_VID - 1)};

	frac_t            fract;		// Step for current speed
	logic [15:0]      acc;			// Phase accumulator
	logic [16:0]      acc_sum;		// Bit 16 is the bus tick
	logic             bus_pol;		// 0: next tick is phase 1
	logic [DIV_W-1:0] div_cnt [2];
	logic [1:0]       div_ce;

	// ========================================================================
	// CPU bus ticks
	// ========================================================================
	always_comb
	begin
		case (cpu_speed)
			speed_ql: fract = FRACT_QL;
			speed_16: fract = FRACT_16;
			speed_24: fract = FRACT_24;
			default:  fract = FRACT_FULL;
		endcase
	end

	assign acc_sum = {1'b0, acc} + fract;

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			acc      <= '0;
			bus_pol  <= 1'b0;
			ce_bus_p <= 1'b0;
			ce_bus_n <= 1'b0;
		end
		else
		begin
			acc      <= acc_sum[15:0];
			ce_bus_p <= acc_sum[16] && !bus_pol;	// Carry shows up next cycle
			ce_bus_n <= acc_sum[16] && bus_pol;
			bus_pol  <= bus_pol ^ acc_sum[16];		// Flip on every tick
		end
	end

	// ========================================================================
	// Refresh/RTC and pixel dividers
	// ========================================================================
	always_ff @(posedge clk_sys)
	begin
		for (int i = 0; i < 2; i++)
		begin
			if (reset)
			begin
				div_cnt[i] <= '0;
				div_ce[i]  <= 1'b0;
			end
			else
			begin
				div_ce[i]  <= (div_cnt[i] == '0);	// First pulse right after reset
				div_cnt[i] <= (div_cnt[i] == DIV_LAST[i]) ? '0 : div_cnt[i] + 1'b1;
			end
		end
	end

	assign ce_131k = div_ce[0];		// SDRAM refresh and RTC
	assign ce_vid  = div_ce[1];		// Pixel clock

endmodule

// File: verilog/address_decode.sv
`timescale 1ns/100ps
// CPU address masking and region decode
// SDRAM, VRAM and peripheral strobes, GoldCard shadow accesses
module address_decode
(
	input  logic [23:1]           cpu_addr16,
	input  logic                  cpu_as,
	input  logic                  cpu_rw,
	input  logic                  cpu_uds,
	input  logic                  cpu_lds,
	input  ql_bus_pkg::ram_cfg_t  ram_cfg,
	input  logic                  gc_en,
	input  logic                  rom_shadow,
	output ql_bus_pkg::bus_addr_t cpu_addr,
	output logic                  cpu_rd,
	output logic                  gc_io_wr,
	output logic                  mc_stat_wr,
	output logic                  qlsd_sel,
	output logic                  qlsd_rd,
	output logic                  zx8302_sel,
	output logic                  qimi_sel,
	output logic                  vram_wr,
	output logic                  sdram_oe,
	output logic                  sdram_wr,
	output logic                  shadow_access,
	output logic                  cpu_rom,
	output logic                  cpu_os_rom,
	output logic                  cpu_ext_rom,
	output logic                  cpu_ram,
	output logic                  ql_io,
	output logic                  gc_boot_rom,
	output logic                  gc_os_rom
);
	import ql_bus_pkg::*;

	// Region bases, compared against the upper address bits
	localparam logic [9:0]  IO_PAGE      = 10'h006;		// 18000-1BFFF
	localparam logic [6:0]  BRAM_BANK    = 7'h01;		// 20000-3FFFF
	localparam logic [9:0]  EXT_ROM_PAGE = 10'h003;		// C000-FFFF
	localparam logic [15:0] GC_IO_PAGE   = 16'h01C0;		// 1C000-1C0FF
	localparam logic [8:0]  GC_RAM1_PAGE = 9'h002;		// 10000-17FFF
	localparam logic [9:0]  GC_RAM2_PAGE = 10'h007;		// 1C100-1FFFF
	localparam logic [7:0]  GC_BOOT_BANK = 8'h04;		// Boot ROM copy
	localparam logic [7:0]  GC_OS_BANK   = 8'h40;		// OS ROM copy

	bus_addr_t addr_mask;
	logic      cpu_wr;
	logic      cpu_io;
	logic      bram;			// Base 128k
	logic      xram;			// Extended RAM
	logic      gc_io;
	logic      gc_ram;
	logic      qlsd_en;
	logic      shadow_rd;
	logic      shadow_wr;

	// ========================================================================
	// Address
	// ========================================================================
	always_comb
	begin
		case (ram_cfg)
			ram_128k:  addr_mask = MASK_128K;
			ram_4096k: addr_mask = MASK_8M;
			default:   addr_mask = MASK_1M;
		endcase
	end

	// Odd byte only when lower strobe alone is active
	assign cpu_addr = {cpu_addr16, !cpu_uds && cpu_lds} & addr_mask;

	assign cpu_rd = cpu_as && cpu_rw && (cpu_uds || cpu_lds);
	assign cpu_wr = cpu_as && !cpu_rw && (cpu_uds || cpu_lds);
	assign cpu_io = cpu_rd || cpu_wr;

	// ========================================================================
	// Regions
	// ========================================================================
	always_comb
	begin
		case (ram_cfg)
			ram_640k:  xram = (cpu_addr[23:20] == '0) && ^cpu_addr[19:18];	// 40000-BFFFF
			ram_896k:  xram = (cpu_addr[23:20] == '0) && |cpu_addr[19:18];	// 40000-FFFFF
			ram_4096k: xram = (cpu_addr[23:22] == '0) && |cpu_addr[21:18];	// 40000-3FFFFF
			default:   xram = 1'b0;
		endcase
	end

	assign ql_io       = cpu_addr[23:14] == IO_PAGE;
	assign bram        = cpu_addr[23:17] == BRAM_BANK;
	assign cpu_rom     = cpu_addr[23:16] == '0;
	assign cpu_ext_rom = cpu_addr[23:14] == EXT_ROM_PAGE;
	assign cpu_os_rom  = cpu_rom && !cpu_ext_rom;		// 0-BFFF

	// GoldCard spaces
	assign gc_io       = gc_en && (cpu_addr[23:8] == GC_IO_PAGE);
	assign gc_ram      = gc_en && ((cpu_addr[23:15] == GC_RAM1_PAGE) ||
		((cpu_addr[23:14] == GC_RAM2_PAGE) && !gc_io));
	assign gc_boot_rom = gc_en && (cpu_addr[23:16] == GC_BOOT_BANK);
	assign gc_os_rom   = gc_en && (cpu_addr[23:16] == GC_OS_BANK);

	assign cpu_ram = bram || xram || gc_ram;

	// ========================================================================
	// Strobes
	// ========================================================================
	assign gc_io_wr   = gc_io && cpu_wr;
	assign mc_stat_wr = ql_io && ({cpu_addr[6:5], cpu_addr[1]} == 3'b111) && cpu_wr && cpu_lds;
	assign vram_wr    = cpu_wr && (cpu_addr[23:16] == VRAM_BANK);

	// QL-SD sits in ROM space, hidden by GoldCard boot ROM
	assign qlsd_en  = (!gc_en || rom_shadow) && cpu_rom && cpu_rd;
	assign qlsd_sel = qlsd_en && ((cpu_addr[15:4] == 12'hFEE) || (cpu_addr[15:4] == 12'hFEF) ||
		(cpu_addr[15:8] == 8'hFF));
	assign qlsd_rd  = qlsd_en && (cpu_addr[15:0] == QLSD_DATA_ADDR);

	assign zx8302_sel = cpu_io && ql_io && !cpu_addr[6];
	assign qimi_sel   = cpu_io && ql_io && (cpu_addr[13:8] == 6'h3F);	// Mouse at 1BFxx

	// OS ROM reads from SDRAM once shadowed, writes fill it before
	assign shadow_rd     = cpu_rd && cpu_os_rom && rom_shadow;
	assign shadow_wr     = cpu_as && !cpu_rw && cpu_os_rom && !rom_shadow;
	assign shadow_access = shadow_rd || shadow_wr;

	assign sdram_oe = cpu_rd && (cpu_ram || shadow_rd);
	assign sdram_wr = cpu_as && !cpu_rw && (cpu_ram || shadow_wr);

endmodule

// File: verilog/bus_control.sv
`timescale 1ns/100ps
// Reset stretcher in bus ticks, RAM size latch
// GoldCard shadow register and video mode register
module bus_control
#(
	parameter int unsigned RESET_TICKS = 4095
)
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  rom_download,
	input  logic                  ce_bus_p,
	input  ql_bus_pkg::ram_cfg_t  ram_cfg_sel,
	input  logic                  gc_io_wr,
	input  logic                  mc_stat_wr,
	input  ql_bus_pkg::bus_addr_t cpu_addr,
	input  logic                  cpu_uds,
	input  logic                  cpu_lds,
	input  ql_bus_pkg::bus_word_t cpu_dout,
	output logic                  sys_reset,
	output ql_bus_pkg::ram_cfg_t  ram_cfg,
	output logic                  gc_en,
	output logic                  rom_shadow,
	output logic [7:0]            mc_stat
);
	import ql_bus_pkg::*;

	localparam int unsigned CNT_W = $clog2(RESET_TICKS + 1);

	logic [CNT_W-1:0] reset_cnt;	// Bus ticks left in reset
	logic             hi_byte_wr;	// GoldCard I/O write, upper byte only

	// ========================================================================
	// Reset stretcher
	// ========================================================================
	always_ff @(posedge clk_sys)
	begin
		if (reset || rom_download)
			reset_cnt <= CNT_W'(RESET_TICKS);	// Reload while held
		else if (ce_bus_p && (reset_cnt != '0))
			reset_cnt <= reset_cnt - 1'b1;
	end

	assign sys_reset = (reset_cnt != '0);

	// RAM size only taken while the system is in reset
	always_ff @(posedge clk_sys)
	begin
		if (sys_reset)
			ram_cfg <= ram_cfg_sel;
	end

	assign gc_en = (ram_cfg == ram_4096k);

	// ========================================================================
	// GoldCard shadow and video mode
	// ========================================================================
	assign hi_byte_wr = gc_io_wr && cpu_uds && !cpu_lds;

	always_ff @(posedge clk_sys)
	begin
		if (sys_reset)
			rom_shadow <= 1'b0;
		else if (hi_byte_wr && (cpu_addr[7:0] == GLO_RENA))
			rom_shadow <= 1'b1;		// OS ROM now served from SDRAM
		else if (hi_byte_wr && (cpu_addr[7:0] == GLO_RDIS))
			rom_shadow <= 1'b0;
	end

	// ZX8301 write-only register at 18063
	always_ff @(posedge clk_sys)
	begin
		if (sys_reset)
			mc_stat <= 8'h00;
		else if (mc_stat_wr)
			mc_stat <= cpu_dout[7:0];
	end

endmodule

// File: verilog/read_return.sv
`timescale 1ns/100ps
// CPU read data mux for QL and GoldCard memory maps
// Data acknowledge select
module read_return
(
	input  logic                  gc_en,
	input  logic                  rom_shadow,
	input  logic                  cpu_rd,
	input  logic                  qlsd_rd,
	input  logic                  cpu_rom,
	input  logic                  cpu_os_rom,
	input  logic                  cpu_ext_rom,
	input  logic                  cpu_ram,
	input  logic                  ql_io,
	input  logic                  gc_boot_rom,
	input  logic                  gc_os_rom,
	input  logic                  qlsd_sel,
	input  logic                  zx8302_sel,
	input  logic                  qimi_sel,
	input  logic                  shadow_access,
	input  ql_bus_pkg::bus_word_t sdram_dout,
	input  ql_bus_pkg::bus_word_t ql_rom_dout,
	input  ql_bus_pkg::bus_word_t gc_rom_dout,
	input  logic [7:0]            qlsd_dout,
	input  ql_bus_pkg::bus_word_t zx8302_dout,
	input  logic [7:0]            qimi_data,
	input  logic                  sdram_dtack,
	input  logic                  qlsd_dtack,
	output ql_bus_pkg::bus_word_t cpu_din,
	output logic                  cpu_dtack
);
	import ql_bus_pkg::*;

	bus_word_t io_dout;
	bus_word_t gc_boot_dout;
	bus_word_t gc_shadow_dout;
	bus_word_t ql_dout;
	bus_word_t map_dout;

	// Internal I/O, always mapped
	assign io_dout = qimi_sel   ? {qimi_data, qimi_data} :
		zx8302_sel ? zx8302_dout : 16'h0000;

	// GoldCard boot, shadow RAM off
	assign gc_boot_dout = cpu_rom ? gc_rom_dout :		// 0-FFFF boot ROM
		gc_boot_rom ? gc_rom_dout :			// 40000 copy
		gc_os_rom   ? ql_rom_dout :			// 400000 original OS
		cpu_ram     ? sdram_dout  : IDLE_WORD;

	// GoldCard with OS ROM shadowed in SDRAM
	assign gc_shadow_dout = cpu_os_rom ? sdram_dout :
		qlsd_rd     ? {qlsd_dout, qlsd_dout} :
		cpu_ext_rom ? ql_rom_dout :
		gc_os_rom   ? ql_rom_dout :
		cpu_ram     ? sdram_dout  : IDLE_WORD;

	// Plain QL, QL-SD data register overlays ROM
	assign ql_dout = qlsd_rd ? {qlsd_dout, qlsd_dout} :
		cpu_rom ? ql_rom_dout :
		cpu_ram ? sdram_dout  : IDLE_WORD;

	assign map_dout = ql_io ? io_dout :
		gc_en ? (rom_shadow ? gc_shadow_dout : gc_boot_dout) : ql_dout;

	assign cpu_din = cpu_rd ? map_dout : IDLE_WORD;	// Bus idles high outside reads

	// Memory model not present, so the rest acks at once
	assign cpu_dtack = qlsd_sel ? qlsd_dtack :
		(shadow_access || cpu_ram) ? sdram_dtack : 1'b1;

endmodule

// File: verilog/ql_bus_top.sv
`timescale 1ns/100ps
// QL bus glue top level with clock enables, reset and GoldCard control
// Holds the timing parameters for an 84 MHz clk_sys
module ql_bus_top
#(
	parameter ql_bus_pkg::frac_t FRACT_QL    = 17'd11702,	// 84 MHz * 11702 / 65536 = 15 MHz
	parameter ql_bus_pkg::frac_t FRACT_16    = 17'd24966,	// 32 MHz
	parameter ql_bus_pkg::frac_t FRACT_24    = 17'd37449,	// 48 MHz
	parameter ql_bus_pkg::frac_t FRACT_FULL  = 17'd65536,
	parameter int unsigned       DIV_131K    = 640,			// 84 MHz / 640 = 131250 Hz
	parameter int unsigned       DIV_VID     = 8,			// 10.5 MHz pixels
	parameter int unsigned       RESET_TICKS = 4095
)
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_bus_pkg::cpu_speed_t cpu_speed,
	input  ql_bus_pkg::ram_cfg_t   ram_cfg_sel,
	input  logic                   rom_download,
	// CPU bus, strobes active high
	input  logic [23:1]            cpu_addr16,
	input  logic                   cpu_as,
	input  logic                   cpu_rw,
	input  logic                   cpu_uds,
	input  logic                   cpu_lds,
	input  ql_bus_pkg::bus_word_t  cpu_dout,
	// Returned data and acknowledges
	input  ql_bus_pkg::bus_word_t  sdram_dout,
	input  ql_bus_pkg::bus_word_t  ql_rom_dout,
	input  ql_bus_pkg::bus_word_t  gc_rom_dout,
	input  logic [7:0]             qlsd_dout,
	input  ql_bus_pkg::bus_word_t  zx8302_dout,
	input  logic [7:0]             qimi_data,
	input  logic                   sdram_dtack,
	input  logic                   qlsd_dtack,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   ce_131k,
	output logic                   ce_vid,
	output logic                   sys_reset,
	output ql_bus_pkg::bus_addr_t  cpu_addr,
	output logic                   sdram_oe,
	output logic                   sdram_wr,
	output logic                   vram_wr,
	output logic                   qlsd_sel,
	output logic                   zx8302_sel,
	output logic                   qimi_sel,
	output logic [7:0]             mc_stat,
	output ql_bus_pkg::bus_word_t  cpu_din,
	output logic                   cpu_dtack
);
	import ql_bus_pkg::*;

	ram_cfg_t ram_cfg;
	logic     gc_en;
	logic     rom_shadow;
	logic     gc_io_wr;
	logic     mc_stat_wr;
	// Region flags
	logic     cpu_rd, qlsd_rd, shadow_access;
	logic     cpu_rom, cpu_os_rom, cpu_ext_rom, cpu_ram;
	logic     ql_io, gc_boot_rom, gc_os_rom;

	// ========================================================================
	// Clock enables run from the raw reset so the stretcher sees ticks
	// ========================================================================
	clock_enables #(
		.FRACT_QL   (FRACT_QL),
		.FRACT_16   (FRACT_16),
		.FRACT_24   (FRACT_24),
		.FRACT_FULL (FRACT_FULL),
		.DIV_131K   (DIV_131K),
		.DIV_VID    (DIV_VID)
	) u_clock_enables (
		.clk_sys, .reset, .cpu_speed,
		.ce_bus_p, .ce_bus_n, .ce_131k, .ce_vid
	);

	bus_control #(
		.RESET_TICKS (RESET_TICKS)
	) u_bus_control (
		.clk_sys, .reset, .rom_download, .ce_bus_p, .ram_cfg_sel,
		.gc_io_wr, .mc_stat_wr, .cpu_addr, .cpu_uds, .cpu_lds, .cpu_dout,
		.sys_reset, .ram_cfg, .gc_en, .rom_shadow, .mc_stat
	);

	// ========================================================================
	// Combinational bus path
	// ========================================================================
	address_decode u_address_decode (
		.cpu_addr16, .cpu_as, .cpu_rw, .cpu_uds, .cpu_lds,
		.ram_cfg, .gc_en, .rom_shadow,
		.cpu_addr, .cpu_rd, .gc_io_wr, .mc_stat_wr,
		.qlsd_sel, .qlsd_rd, .zx8302_sel, .qimi_sel, .vram_wr,
		.sdram_oe, .sdram_wr, .shadow_access,
		.cpu_rom, .cpu_os_rom, .cpu_ext_rom, .cpu_ram,
		.ql_io, .gc_boot_rom, .gc_os_rom
	);

	read_return u_read_return (
		.gc_en, .rom_shadow, .cpu_rd, .qlsd_rd,
		.cpu_rom, .cpu_os_rom, .cpu_ext_rom, .cpu_ram,
		.ql_io, .gc_boot_rom, .gc_os_rom,
		.qlsd_sel, .zx8302_sel, .qimi_sel, .shadow_access,
		.sdram_dout, .ql_rom_dout, .gc_rom_dout, .qlsd_dout,
		.zx8302_dout, .qimi_data, .sdram_dtack, .qlsd_dtack,
		.cpu_din, .cpu_dtack
	);

endmodule

// File: include/ql_bus_model.svh
// Reference functions for the bus glue checks
// Galois LFSR, address mask and map, selects, read word and acknowledge
`ifndef QL_BUS_MODEL_SVH
`define QL_BUS_MODEL_SVH

// Regions of one byte address, written as plain ranges
typedef struct packed
{
	logic rom;
	logic ext_rom;
	logic ram;
	logic io;
	logic gc_boot;
	logic gc_os;
} model_map_t;

// One Galois step, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] galois_step(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// Takes n bits, stepping once per bit
function automatic logic [31:0] random_bits(inout logic [31:0] s, input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++)
	begin
		r = {r[30:0], s[0]};
		s = galois_step(s);
	end
	return r;
endfunction

function automatic ql_bus_pkg::bus_addr_t masked_addr(input logic [23:1] a16,
		input logic uds, input logic lds, input ql_bus_pkg::ram_cfg_t cfg);
	ql_bus_pkg::bus_addr_t mask;
	case (cfg)
		ql_bus_pkg::ram_128k:  mask = 24'h03FFFF;
		ql_bus_pkg::ram_4096k: mask = 24'h7FFFFF;
		default:               mask = 24'h0FFFFF;
	endcase
	return {a16, !uds && lds} & mask;
endfunction

function automatic model_map_t decode_regions(input ql_bus_pkg::bus_addr_t a,
		input ql_bus_pkg::ram_cfg_t cfg);
	model_map_t m;
	logic       gc;
	logic       xram;
	gc        = (cfg == ql_bus_pkg::ram_4096k);
	m.rom     = (a <= 24'h00FFFF);
	m.ext_rom = (a >= 24'h00C000) && m.rom;
	m.io      = (a >= 24'h018000) && (a <= 24'h01BFFF);
	m.gc_boot = gc && (a >= 24'h040000) && (a <= 24'h04FFFF);
	m.gc_os   = gc && (a >= 24'h400000) && (a <= 24'h40FFFF);
	case (cfg)
		ql_bus_pkg::ram_640k:  xram = (a >= 24'h040000) && (a <= 24'h0BFFFF);
		ql_bus_pkg::ram_896k:  xram = (a >= 24'h040000) && (a <= 24'h0FFFFF);
		ql_bus_pkg::ram_4096k: xram = (a >= 24'h040000) && (a <= 24'h3FFFFF);
		default:               xram = 1'b0;
	endcase
	m.ram = ((a >= 24'h020000) && (a <= 24'h03FFFF)) || xram ||
		(gc && (((a >= 24'h010000) && (a <= 24'h017FFF)) ||
		((a >= 24'h01C100) && (a <= 24'h01FFFF))));
	return m;
endfunction

// {sdram_oe, sdram_wr, vram_wr, qlsd_sel, zx8302_sel, qimi_sel, shadow_access}
function automatic logic [6:0] predict_strobes(input ql_bus_pkg::bus_addr_t a,
		input ql_bus_pkg::ram_cfg_t cfg, input logic shadow, input logic as,
		input logic rw, input logic uds, input logic lds);
	model_map_t m;
	logic       rd;
	logic       wr;
	logic       sh_rd;
	logic       sh_wr;
	logic       qlsd;
	m     = decode_regions(a, cfg);
	rd    = as && rw && (uds || lds);
	wr    = as && !rw && (uds || lds);
	sh_rd = rd && m.rom && !m.ext_rom && shadow;
	sh_wr = as && !rw && m.rom && !m.ext_rom && !shadow;
	qlsd  = (cfg != ql_bus_pkg::ram_4096k || shadow) && m.rom && rd && (a[15:5] == 11'h7F7 ||
		a[15:8] == 8'hFF);
	return {rd && (m.ram || sh_rd), as && !rw && (m.ram || sh_wr),
		wr && (a[23:16] == ql_bus_pkg::VRAM_BANK), qlsd,
		(rd || wr) && m.io && !a[6], (rd || wr) && m.io && (a[13:8] == 6'h3F),
		sh_rd || sh_wr};
endfunction

function automatic ql_bus_pkg::bus_word_t expected_din(input ql_bus_pkg::bus_addr_t a,
		input ql_bus_pkg::ram_cfg_t cfg, input logic shadow, input logic rd,
		input ql_bus_pkg::bus_word_t sdram, input ql_bus_pkg::bus_word_t ql_rom,
		input ql_bus_pkg::bus_word_t gc_rom, input logic [7:0] qlsd,
		input ql_bus_pkg::bus_word_t zx, input logic [7:0] qimi);
	model_map_t m;
	logic       gc;
	logic       qlsd_rd;
	m       = decode_regions(a, cfg);
	gc      = (cfg == ql_bus_pkg::ram_4096k);
	qlsd_rd = (!gc || shadow) && (a == 24'h00FEE4);
	if (!rd)
		return ql_bus_pkg::IDLE_WORD;
	if (m.io)
		return (a[13:8] == 6'h3F) ? {qimi, qimi} : (!a[6] ? zx : 16'h0000);
	if (gc && !shadow)
		return (m.rom || m.gc_boot) ? gc_rom : m.gc_os ? ql_rom :
			m.ram ? sdram : ql_bus_pkg::IDLE_WORD;
	if (gc)
		return (m.rom && !m.ext_rom) ? sdram : qlsd_rd ? {qlsd, qlsd} :
			(m.ext_rom || m.gc_os) ? ql_rom : m.ram ? sdram : ql_bus_pkg::IDLE_WORD;
	return qlsd_rd ? {qlsd, qlsd} : m.rom ? ql_rom : m.ram ? sdram : ql_bus_pkg::IDLE_WORD;
endfunction

// Acknowledge from the selects above and the memory map
function automatic logic ack_rule(input logic [6:0] sel, input logic ram,
		input logic sdram_dtack, input logic qlsd_dtack);
	return sel[3] ? qlsd_dtack : (sel[0] || ram) ? sdram_dtack : 1'b1;
endfunction

`endif

// File: testbench/tb_ql_bus.sv
`timescale 1ns/100ps
// Testbench for the QL bus glue with cycle model of enables and registers
// Random bus stimulus, GoldCard shadow and video register sequences
module tb_ql_bus;
	import ql_bus_pkg::*;

	`include "ql_bus_model.svh"

	localparam frac_t       STEP_QL     = 17'd11702;
	localparam frac_t       STEP_16     = 17'd24966;
	localparam frac_t       STEP_24     = 17'd37449;
	localparam frac_t       STEP_FULL   = 17'd65536;
	localparam int unsigned DIV_131K    = 640;
	localparam int unsigned DIV_VID     = 8;
	localparam int unsigned RESET_TICKS = 8;		// Short stretch for simulation
	localparam int          WAIT_LIMIT  = 2000;		// Cycles before a wait gives up

	logic        clk_sys      = 1'b0;
	logic        reset        = 1'b1;
	cpu_speed_t  cpu_speed    = speed_ql;
	ram_cfg_t    ram_cfg_sel  = ram_128k;
	logic        rom_download = 1'b0;
	logic [23:1] cpu_addr16   = '0;
	logic        cpu_as       = 1'b0;
	logic        cpu_rw       = 1'b1;
	logic        cpu_uds      = 1'b0;
	logic        cpu_lds      = 1'b0;
	bus_word_t   cpu_dout     = '0;
	bus_word_t   sdram_dout   = '0;
	bus_word_t   ql_rom_dout  = '0;
	bus_word_t   gc_rom_dout  = '0;
	logic [7:0]  qlsd_dout    = '0;
	bus_word_t   zx8302_dout  = '0;
	logic [7:0]  qimi_data    = '0;
	logic        sdram_dtack  = 1'b0;
	logic        qlsd_dtack   = 1'b0;
	logic        ce_bus_p, ce_bus_n, ce_131k, ce_vid;
	logic        sys_reset;
	bus_addr_t   cpu_addr;
	logic        sdram_oe, sdram_wr, vram_wr;
	logic        qlsd_sel, zx8302_sel, qimi_sel;
	logic [7:0]  mc_stat;
	bus_word_t   cpu_din;
	logic        cpu_dtack;

	logic [31:0] seed = 32'h85d7_0cd3;

	// Model state, holds what the DUT should show after the last edge
	int          acc_m;
	int          ticks_m;				// Bus ticks since reset
	int          run_m;					// Cycles since reset fell
	int          left_m;				// ce_bus_p pulses left in reset
	logic        exp_p       = 1'b0;
	logic        exp_n       = 1'b0;
	logic        exp_131k    = 1'b0;
	logic        exp_vid     = 1'b0;
	logic        exp_sys_rst = 1'b0;
	ram_cfg_t    cfg_m;
	logic        shadow_m;
	logic [7:0]  mc_m;
	logic        started     = 1'b0;	// A reset edge has been seen
	logic        bus_valid   = 1'b0;	// RAM size latched at least once

	always #10 clk_sys = ~clk_sys;		// 20 ns period

	ql_bus_top #(
		.FRACT_QL    (STEP_QL),
		.FRACT_16    (STEP_16),
		.FRACT_24    (STEP_24),
		.FRACT_FULL  (STEP_FULL),
		.DIV_131K    (DIV_131K),
		.DIV_VID     (DIV_VID),
		.RESET_TICKS (RESET_TICKS)
	) uut (.*);

	// ========================================================================
	// Reference helpers
	// ========================================================================
	function automatic int speed_step(input cpu_speed_t s);
		case (s)
			speed_ql: return STEP_QL;
			speed_16: return STEP_16;
			speed_24: return STEP_24;
			default:  return STEP_FULL;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// ========================================================================
	// Comparison process, sampled on the rising edge before any update
	// ========================================================================
	always @(posedge clk_sys)
	begin : compare
		bus_addr_t  a;
		model_map_t m;
		logic [6:0] sel;
		logic       rd;
		logic       wr;
		int         sum;
		if (started)
		begin
			check_value("ce_bus_p", ce_bus_p, exp_p);
			check_value("ce_bus_n", ce_bus_n, exp_n);
			check_value("ce_131k", ce_131k, exp_131k);
			check_value("ce_vid", ce_vid, exp_vid);
			check_value("sys_reset", sys_reset, exp_sys_rst);
		end
		rd = cpu_as && cpu_rw && (cpu_uds || cpu_lds);
		wr = cpu_as && !cpu_rw && (cpu_uds || cpu_lds);
		if (bus_valid)
		begin
			a   = masked_addr(cpu_addr16, cpu_uds, cpu_lds, cfg_m);
			m   = decode_regions(a, cfg_m);
			sel = predict_strobes(a, cfg_m, shadow_m, cpu_as, cpu_rw, cpu_uds, cpu_lds);
			check_value("cpu_addr", cpu_addr, a);
			check_value("sdram_oe", sdram_oe, sel[6]);
			check_value("sdram_wr", sdram_wr, sel[5]);
			check_value("vram_wr", vram_wr, sel[4]);
			check_value("qlsd_sel", qlsd_sel, sel[3]);
			check_value("zx8302_sel", zx8302_sel, sel[2]);
			check_value("qimi_sel", qimi_sel, sel[1]);
			check_value("cpu_din", cpu_din, expected_din(a, cfg_m, shadow_m, rd, sdram_dout,
				ql_rom_dout, gc_rom_dout, qlsd_dout, zx8302_dout, qimi_data));
			check_value("cpu_dtack", cpu_dtack,
				ack_rule(sel, m.ram, sdram_dtack, qlsd_dtack));
			check_value("mc_stat", mc_stat, mc_m);
		end

		// Registers first, they see sys_reset as it was before this edge
		if (started && exp_sys_rst)
		begin
			cfg_m     = ram_cfg_sel;
			shadow_m  = 1'b0;
			mc_m      = 8'h00;
			bus_valid = 1'b1;
		end
		else if (bus_valid)
		begin
			if (wr && (cfg_m == ram_4096k) && cpu_uds && !cpu_lds && (a[23:8] == 16'h01C0))
			begin
				if (a[7:0] == GLO_RENA)
					shadow_m = 1'b1;
				else if (a[7:0] == GLO_RDIS)
					shadow_m = 1'b0;
			end
			if (wr && cpu_lds && m.io && a[6] && a[5] && a[1])	// Video register 18063
				mc_m = cpu_dout[7:0];
		end

		// Reset stretch counts phase 1 ticks once both inputs are low
		if (reset || rom_download)
			left_m = RESET_TICKS;
		else if (started && exp_p && (left_m > 0))
			left_m = left_m - 1;
		exp_sys_rst = (left_m != 0);

		// Enables
		if (reset)
		begin
			acc_m    = 0;
			ticks_m  = 0;
			run_m    = 0;
			exp_p    = 1'b0;
			exp_n    = 1'b0;
			exp_131k = 1'b0;
			exp_vid  = 1'b0;
			started  = 1'b1;
		end
		else
		begin
			sum   = acc_m + speed_step(cpu_speed);
			exp_p = (sum >= 65536) && (ticks_m % 2 == 0);	// Even ticks are phase 1
			exp_n = (sum >= 65536) && (ticks_m % 2 == 1);
			if (sum >= 65536)
				ticks_m++;
			acc_m    = sum % 65536;
			exp_131k = (run_m % DIV_131K) == 0;
			exp_vid  = (run_m % DIV_VID) == 0;
			run_m++;
		end
	end

	// ========================================================================
	// Stimulus, always applied on the falling edge
	// ========================================================================
	task automatic drive_returns();
		sdram_dout  = 16'(random_bits(seed, 16));
		ql_rom_dout = 16'(random_bits(seed, 16));
		gc_rom_dout = 16'(random_bits(seed, 16));
		zx8302_dout = 16'(random_bits(seed, 16));
		qlsd_dout   = 8'(random_bits(seed, 8));
		qimi_data   = 8'(random_bits(seed, 8));
		sdram_dtack = 1'(random_bits(seed, 1));
		qlsd_dtack  = 1'(random_bits(seed, 1));
	endtask

	task automatic drive_access(input logic [23:1] a16, input logic as, input logic rw,
			input logic uds, input logic lds, input bus_word_t data);
		@(negedge clk_sys);
		cpu_addr16 = a16;
		cpu_as     = as;
		cpu_rw     = rw;
		cpu_uds    = uds;
		cpu_lds    = lds;
		cpu_dout   = data;
		drive_returns();
	endtask

	task automatic idle_bus();
		drive_access('0, 1'b0, 1'b1, 1'b0, 1'b0, 16'h0000);
	endtask

	// Biased toward the low 1M and the ROM/I/O area
	task automatic random_access();
		logic [31:0] r;
		logic [23:1] a16;
		r   = random_bits(seed, 23);
		a16 = r[22:0];
		if (random_bits(seed, 1) == 1)
			a16[21:16] = '0;		// GoldCard OS copy when bit 22 set
		if (random_bits(seed, 1) == 1)
			a16[23:20] = '0;
		if (random_bits(seed, 1) == 1)
			a16[19:17] = '0;
		r = random_bits(seed, 5);
		drive_access(a16, r[4] | r[3], r[2], r[1], r[0], 16'(random_bits(seed, 16)));
	endtask

	// Caller sits on a falling edge or at time zero
	task automatic apply_reset(input ram_cfg_t cfg, input cpu_speed_t speed);
		reset       = 1'b1;
		ram_cfg_sel = cfg;
		cpu_speed   = speed;
		cpu_as      = 1'b0;
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic wait_release();
		int i;
		for (i = 0; i < WAIT_LIMIT; i++)
		begin
			@(negedge clk_sys);
			if (!sys_reset)
				break;
		end
		if (i == WAIT_LIMIT)
		begin
			$display("Timed out waiting for sys_reset to fall");
			$display("STATUS: FAIL");
			$fatal(1, "Timeout");
		end
	endtask

	task automatic read_word(input bus_addr_t addr);
		drive_access(addr[23:1], 1'b1, 1'b1, 1'b1, 1'b1, 16'h0000);
		@(posedge clk_sys);			// Outputs settled since the falling edge
	endtask

	initial
	begin
		logic [7:0] vid;

		// Bus enables at every speed, random bus traffic alongside
		for (int s = 0; s < 4; s++)
		begin
			apply_reset(ram_896k, cpu_speed_t'(s));
			wait_release();
			repeat (700) random_access();
		end

		// Each RAM size, later changes of the select must be ignored
		for (int c = 0; c < 4; c++)
		begin
			apply_reset(ram_cfg_t'(c), speed_full);
			wait_release();
			ram_cfg_sel = ram_cfg_t'(c ^ 3);
			repeat (300) random_access();
		end

		// ROM download holds the system in reset again
		@(negedge clk_sys);
		rom_download = 1'b1;
		ram_cfg_sel  = ram_640k;
		@(negedge clk_sys);
		rom_download = 1'b0;
		wait_release();
		ram_cfg_sel = ram_896k;
		repeat (200) random_access();

		// ====================================================================
		// GoldCard boot map, shadow on, shadow off
		// ====================================================================
		apply_reset(ram_4096k, speed_24);
		wait_release();
		repeat (200) random_access();
		read_word(24'h001000);
		check_value("cpu_din", cpu_din, gc_rom_dout);
		drive_access(23'h00E030, 1'b1, 1'b0, 1'b1, 1'b0, 16'h0000);	// Upper byte at 1C060
		read_word(24'h001000);
		check_value("sdram_oe", sdram_oe, 1'b1);
		check_value("cpu_din", cpu_din, sdram_dout);
		read_word({8'h00, QLSD_DATA_ADDR});
		check_value("qlsd_sel", qlsd_sel, 1'b1);
		check_value("cpu_din", cpu_din, {qlsd_dout, qlsd_dout});
		repeat (200) random_access();
		drive_access(23'h00E032, 1'b1, 1'b0, 1'b1, 1'b0, 16'h0000);	// Upper byte at 1C064
		read_word(24'h001000);
		check_value("cpu_din", cpu_din, gc_rom_dout);
		repeat (100) random_access();

		// Small RAM means plain QL map
		idle_bus();
		apply_reset(ram_128k, speed_16);
		wait_release();
		read_word(24'h001000);
		check_value("cpu_din", cpu_din, ql_rom_dout);

		// Video mode register takes the low data byte
		vid = 8'(random_bits(seed, 8));
		drive_access(23'h00C031, 1'b1, 1'b0, 1'b0, 1'b1, {8'h5A, vid});	// Byte at 18063
		idle_bus();
		check_value("mc_stat", mc_stat, vid);
		repeat (100) random_access();
		idle_bus();

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: flist.f
+incdir+include
verilog/ql_bus_pkg.sv
verilog/clock_enables.sv
verilog/address_decode.sv
verilog/bus_control.sv
verilog/read_return.sv
verilog/ql_bus_top.sv
testbench/tb_ql_bus.sv

// File: Bender.yml
package:
  name: ql_bus_glue

sources:
  - files:
      - verilog/ql_bus_pkg.sv
      - verilog/clock_enables.sv
      - verilog/address_decode.sv
      - verilog/bus_control.sv
      - verilog/read_return.sv
      - verilog/ql_bus_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_ql_bus.sv
